// ==== spi_consts.svh ====
// sizes, apb offsets and reset values shared by the spi master and its testbench
// frames are fixed at SPI_FRAME_BITS, fifo depth is 2**SPI_FIFO_AW entries
// offsets are byte addresses, sized to SPI_APB_AW bits
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

//==========================================================================
// frame and fifo geometry
//==========================================================================
`define SPI_FRAME_BITS 8
// 3 address bits, depth 8, levels need one bit more
`define SPI_FIFO_AW 3

//==========================================================================
// apb register map
//==========================================================================
`define SPI_APB_AW 5
`define SPI_ADDR_CTRL 5'h00
`define SPI_ADDR_TIMING 5'h04
`define SPI_ADDR_STATUS 5'h08
`define SPI_ADDR_TXDATA 5'h0c
// highest legal offset, anything above errors
`define SPI_ADDR_RXDATA 5'h10

// frame_gap 2 in byte 1, clk_div 1 in byte 0
`define SPI_TIMING_RESET 32'h0000_0201

`endif

// ==== spi_reg_pkg.sv ====
// register layouts of the apb side of the spi master
// reserved fields read as zero and ignore writes
// status bit positions are fixed from bit 0 upwards
`default_nettype none

`include "spi_consts.svh"

package spi_reg_pkg;

	// ctrl, bits 0 to 6
	typedef struct packed {
		logic [24:0] rsvd;
		logic        soft_reset;
		logic [1:0]  slave_sel;
		logic        lsb_first;
		logic        cpha;
		logic        cpol;
		logic        enable;
	} ctrl_t;

	// timing, half period is clk_div+1 pclk cycles
	typedef struct packed {
		logic [15:0] rsvd;
		logic [7:0]  frame_gap;
		logic [7:0]  clk_div;
	} timing_t;

	// one pwdata word, seen as ctrl or as timing depending on paddr
	typedef union packed {
		ctrl_t   ctrl;
		timing_t timing;
	} wdata_u;

	// status, read only
	typedef struct packed {
		logic [31-2*(`SPI_FIFO_AW+1)-7:0] rsvd;
		logic                   rx_overflow;
		logic                   tx_overflow;
		logic                   busy;
		logic                   rx_empty;
		logic                   rx_full;
		logic                   tx_empty;
		logic                   tx_full;
		logic [`SPI_FIFO_AW:0]  rx_level;
		logic [`SPI_FIFO_AW:0]  tx_level;
	} status_t;

endpackage

`default_nettype wire

// ==== spi_xfer_pkg.sv ====
// transfer side types, shared by fifos, sequencer and shift engine
`default_nettype none

`include "spi_consts.svh"

package spi_xfer_pkg;

	// one spi frame, msb is the first bit on the wire
	typedef logic [`SPI_FRAME_BITS-1:0] frame_t;

	// frame scheduler
	typedef enum logic [1:0] {
		seq_idle,
		seq_start,
		seq_wait_done,
		seq_gap
	} seq_state_t;

	// shift engine
	typedef enum logic {
		eng_idle,
		eng_shift
	} eng_state_t;

endpackage

`default_nettype wire

// ==== spi_fifo.sv ====
// synchronous show-ahead fifo of spi frames, depth 2**AW
// push when full and pop when empty are dropped, callers must avoid them
// clear empties the fifo in one cycle and wins over push and pop
`timescale 1ns/100ps
`default_nettype none

`include "spi_consts.svh"

module spi_fifo #(
	parameter int AW = `SPI_FIFO_AW
) (
	input  wire logic                 pclk,
	input  wire logic                 preset_n,
	input  wire logic                 clear,
	input  wire logic                 push,
	input  wire spi_xfer_pkg::frame_t wdata,
	input  wire logic                 pop,
	output spi_xfer_pkg::frame_t      rdata,
	output logic [AW:0]               level,
	output logic                      full,
	output logic                      empty
);

	// pointers carry one wrap bit above the ram address
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic wr_en;
	logic rd_en;
	spi_xfer_pkg::frame_t mem [2**AW];

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge pclk)
	begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

	// head entry visible without a pop
	assign rdata = mem[rd_ptr[AW-1:0]];

	// same address, wrap bits differ when full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign level = wr_ptr - rd_ptr;

	// producers gate their own strobes with the flags
	a_no_push_full: assert property (@(posedge pclk) disable iff (!preset_n)
		push && !clear |-> !full)
		else $error("spi_fifo push while full");
	a_no_pop_empty: assert property (@(posedge pclk) disable iff (!preset_n)
		pop && !clear |-> !empty)
		else $error("spi_fifo pop while empty");

endmodule

`default_nettype wire

// ==== spi_apb_regs.sv ====
// apb slave of the spi master, pready is tied high so there are no wait states
// prdata and pslverr are captured in setup and held through the access phase
// writes, tx pushes and rx pops take effect at the end of the access phase
`timescale 1ns/100ps
`default_nettype none

`include "spi_consts.svh"

module spi_apb_regs (
	input  wire logic                    pclk,
	input  wire logic                    preset_n,
	input  wire logic                    psel,
	input  wire logic                    penable,
	input  wire logic                    pwrite,
	input  wire logic [`SPI_APB_AW-1:0]  paddr,
	input  wire logic [31:0]             pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,
	output spi_reg_pkg::ctrl_t           ctrl,
	output spi_reg_pkg::timing_t         timing,
	input  wire logic                    busy,
	output logic                         tx_push,
	output spi_xfer_pkg::frame_t         tx_wdata,
	input  wire logic [`SPI_FIFO_AW:0]   tx_level,
	input  wire logic                    tx_full,
	input  wire logic                    tx_empty,
	output logic                         rx_pop,
	input  wire spi_xfer_pkg::frame_t    rx_rdata,
	input  wire logic [`SPI_FIFO_AW:0]   rx_level,
	input  wire logic                    rx_full,
	input  wire logic                    rx_empty,
	output logic                         fifo_clear
);

	spi_reg_pkg::wdata_u  wv;
	spi_reg_pkg::ctrl_t   ctrl_wr;
	spi_reg_pkg::timing_t timing_wr;
	spi_reg_pkg::status_t status;
	logic setup;
	logic access;
	logic bad;
	logic wr_ok;
	// legal rxdata read in flight, and whether a byte was there at setup
	logic rx_rd_q;
	logic rx_hit_q;
	logic tx_overflow;
	logic rx_overflow;
	logic [31:0] rd_mux;

	//==========================================================================
	// decode
	//==========================================================================
	assign setup  = psel && !penable;
	assign access = psel && penable;

	// unaligned, past rxdata, read-only written, write-only read
	assign bad = (paddr[1:0] != 2'b00) || (paddr > `SPI_ADDR_RXDATA)
		|| (pwrite && (paddr == `SPI_ADDR_STATUS || paddr == `SPI_ADDR_RXDATA))
		|| (!pwrite && paddr == `SPI_ADDR_TXDATA);

	// pslverr holds this access's error during the access phase
	assign wr_ok  = access && pwrite && !pslverr;
	assign pready = 1'b1;

	// both views of one write word, reserved bits dropped
	assign wv = pwdata;
	always_comb
	begin
		ctrl_wr = wv.ctrl;
		ctrl_wr.rsvd = '0;
		timing_wr = wv.timing;
		timing_wr.rsvd = '0;
	end

	//==========================================================================
	// control, timing and sticky overflow
	//==========================================================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			ctrl <= '0;
			timing <= `SPI_TIMING_RESET;
			tx_overflow <= 1'b0;
			rx_overflow <= 1'b0;
		end
		else
		begin
			if (wr_ok && paddr == `SPI_ADDR_CTRL)
				ctrl <= ctrl_wr;
			if (wr_ok && paddr == `SPI_ADDR_TIMING)
				timing <= timing_wr;
			// cleared while soft reset is held
			if (ctrl.soft_reset)
			begin
				tx_overflow <= 1'b0;
				rx_overflow <= 1'b0;
			end
			else
			begin
				if (wr_ok && paddr == `SPI_ADDR_TXDATA && tx_full)
					tx_overflow <= 1'b1;
				if (access && rx_rd_q && !rx_hit_q)
					rx_overflow <= 1'b1;
			end
		end
	end

	assign fifo_clear = ctrl.soft_reset;

	// a full tx fifo drops the byte
	assign tx_push  = wr_ok && paddr == `SPI_ADDR_TXDATA && !tx_full;
	assign tx_wdata = pwdata[`SPI_FRAME_BITS-1:0];
	assign rx_pop   = access && rx_rd_q && rx_hit_q;

	//==========================================================================
	// read back
	//==========================================================================
	always_comb
	begin
		status = '0;
		status.tx_level = tx_level;
		status.rx_level = rx_level;
		status.tx_full = tx_full;
		status.tx_empty = tx_empty;
		status.rx_full = rx_full;
		status.rx_empty = rx_empty;
		status.busy = busy;
		status.tx_overflow = tx_overflow;
		status.rx_overflow = rx_overflow;
	end

	always_comb
	begin
		case (paddr)
			`SPI_ADDR_CTRL:   rd_mux = ctrl;
			`SPI_ADDR_TIMING: rd_mux = timing;
			`SPI_ADDR_STATUS: rd_mux = status;
			// empty rx fifo reads as zero
			`SPI_ADDR_RXDATA: rd_mux = rx_empty ? '0 : 32'(rx_rdata);
			default:          rd_mux = '0;
		endcase
	end

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			prdata <= '0;
			pslverr <= 1'b0;
			rx_rd_q <= 1'b0;
			rx_hit_q <= 1'b0;
		end
		else
		begin
			pslverr <= setup && bad;
			rx_rd_q <= setup && !pwrite && !bad && paddr == `SPI_ADDR_RXDATA;
			if (setup)
			begin
				rx_hit_q <= !rx_empty;
				if (!pwrite)
					prdata <= rd_mux;
			end
		end
	end

endmodule

`default_nettype wire

// ==== spi_sequencer.sv ====
// frame scheduler between the tx fifo, the shift engine and the rx fifo
// a frame starts only with room in the rx fifo, so rx never overflows
// soft reset returns to idle while a frame already in the engine still runs out
`timescale 1ns/100ps
`default_nettype none

module spi_sequencer (
	input  wire logic                 pclk,
	input  wire logic                 preset_n,
	input  wire logic                 enable,
	input  wire logic                 soft_reset,
	input  wire logic [7:0]           frame_gap,
	input  wire logic                 tx_empty,
	input  wire spi_xfer_pkg::frame_t tx_rdata,
	output logic                      tx_pop,
	input  wire logic                 rx_full,
	output logic                      rx_push,
	output spi_xfer_pkg::frame_t      rx_wdata,
	output logic                      frame_start,
	output spi_xfer_pkg::frame_t      frame_data,
	input  wire logic                 frame_done,
	input  wire spi_xfer_pkg::frame_t rx_frame
);

	spi_xfer_pkg::seq_state_t state;
	spi_xfer_pkg::seq_state_t state_nxt;
	logic [7:0] gap_cnt;
	// engine still owns a frame even across a soft reset
	logic in_flight;
	logic can_start;

	assign can_start = enable && !soft_reset && !tx_empty && !rx_full && !in_flight;

	always_comb
	begin
		state_nxt = state;
		case (state)
			spi_xfer_pkg::seq_idle:
				if (can_start)
					state_nxt = spi_xfer_pkg::seq_start;
			spi_xfer_pkg::seq_start:
				state_nxt = spi_xfer_pkg::seq_wait_done;
			spi_xfer_pkg::seq_wait_done:
				if (frame_done)
					state_nxt = spi_xfer_pkg::seq_gap;
			spi_xfer_pkg::seq_gap:
				// back to back when the next byte is ready
				if (gap_cnt == 8'd0)
					state_nxt = can_start ? spi_xfer_pkg::seq_start : spi_xfer_pkg::seq_idle;
			default:
				state_nxt = spi_xfer_pkg::seq_idle;
		endcase
		if (soft_reset)
			state_nxt = spi_xfer_pkg::seq_idle;
	end

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			state <= spi_xfer_pkg::seq_idle;
			gap_cnt <= '0;
			in_flight <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == spi_xfer_pkg::seq_wait_done && frame_done)
				gap_cnt <= frame_gap;
			else if (state == spi_xfer_pkg::seq_gap && gap_cnt != 8'd0)
				gap_cnt <= gap_cnt - 8'd1;
			if (frame_start)
				in_flight <= 1'b1;
			else if (frame_done)
				in_flight <= 1'b0;
		end
	end

	// show-ahead head is the frame and is popped in the same cycle
	assign frame_start = (state == spi_xfer_pkg::seq_start) && !soft_reset;
	assign tx_pop      = frame_start;
	assign frame_data  = tx_rdata;

	// received byte goes straight into the rx fifo on done
	assign rx_push  = (state == spi_xfer_pkg::seq_wait_done) && frame_done;
	assign rx_wdata = rx_frame;

	// every done answers a frame started here, also after a soft reset cut the fsm short
	a_one_frame: assert property (@(posedge pclk) disable iff (!preset_n)
		frame_done |-> in_flight)
		else $error("spi_sequencer frame_done with no frame in flight");

endmodule

`default_nettype wire

// ==== spi_master_engine.sv ====
// spi shift engine, sclk is a registered output of pclk logic, not a clock
// half period is clk_div+1 pclk cycles, a frame is 2*SPI_FRAME_BITS half periods
// mode, bit order and slave select are used live, change them only between frames
`timescale 1ns/100ps
`default_nettype none

`include "spi_consts.svh"

module spi_master_engine (
	input  wire logic                 pclk,
	input  wire logic                 preset_n,
	input  wire logic                 cpol,
	input  wire logic                 cpha,
	input  wire logic                 lsb_first,
	input  wire logic [1:0]           slave_sel,
	input  wire logic [7:0]           clk_div,
	input  wire logic                 frame_start,
	input  wire spi_xfer_pkg::frame_t frame_data,
	output logic                      frame_done,
	output spi_xfer_pkg::frame_t      rx_frame,
	output logic                      busy,
	output logic                      sclk,
	output logic                      mosi,
	input  wire logic                 miso,
	output logic [3:0]                ss_n
);

	localparam int W = `SPI_FRAME_BITS;
	localparam int EDGES = 2 * W;

	spi_xfer_pkg::eng_state_t state;
	logic [7:0] div_cnt;
	logic [$clog2(EDGES)-1:0] edge_cnt;
	spi_xfer_pkg::frame_t tx_sr;
	spi_xfer_pkg::frame_t rx_sr;
	spi_xfer_pkg::frame_t load_val;
	logic start_ok;
	logic half_tick;
	logic last_edge;
	logic lead_edge;
	logic sample_now;
	logic drive_now;

	function automatic spi_xfer_pkg::frame_t bit_rev(input spi_xfer_pkg::frame_t d);
		spi_xfer_pkg::frame_t r;
		for (int i = 0; i < W; i++)
		begin
			r[i] = d[W-1-i];
		end
		return r;
	endfunction

	// lsb first is msb first on a reversed frame
	assign load_val = lsb_first ? bit_rev(frame_data) : frame_data;
	assign start_ok = frame_start && (state == spi_xfer_pkg::eng_idle);

	//==========================================================================
	// divider and sclk
	//==========================================================================
	assign half_tick = (state == spi_xfer_pkg::eng_shift) && (div_cnt == clk_div);
	assign last_edge = (edge_cnt == EDGES - 1);
	// even edges lead, odd edges trail
	assign lead_edge = !edge_cnt[0];
	// cpha 0 samples on lead, cpha 1 on trail, mosi moves on the other one
	assign sample_now = half_tick && (lead_edge != cpha);
	assign drive_now  = half_tick && (lead_edge == cpha);

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			state <= spi_xfer_pkg::eng_idle;
			div_cnt <= '0;
			edge_cnt <= '0;
			// cpol resets to 0
			sclk <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= half_tick && last_edge;
			case (state)
				spi_xfer_pkg::eng_idle:
				begin
					sclk <= cpol;
					if (frame_start)
					begin
						state <= spi_xfer_pkg::eng_shift;
						div_cnt <= '0;
						edge_cnt <= '0;
					end
				end
				default:
				begin
					if (half_tick)
					begin
						div_cnt <= '0;
						sclk <= !sclk;
						edge_cnt <= edge_cnt + 1'b1;
						// 16th toggle leaves sclk back at cpol
						if (last_edge)
							state <= spi_xfer_pkg::eng_idle;
					end
					else
						div_cnt <= div_cnt + 8'd1;
				end
			endcase
		end
	end

	//==========================================================================
	// shift and sample
	//==========================================================================
	// cpha 0 puts bit 0 of the wire on mosi at load, so the register starts one ahead
	always_ff @(posedge pclk)
	begin
		if (start_ok)
			tx_sr <= cpha ? load_val : {load_val[W-2:0], 1'b0};
		else if (drive_now)
			tx_sr <= {tx_sr[W-2:0], 1'b0};
		if (sample_now)
			rx_sr <= {rx_sr[W-2:0], miso};
	end

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
			mosi <= 1'b0;
		else if (start_ok)
			mosi <= load_val[W-1];
		else if (drive_now)
			mosi <= tx_sr[W-1];
	end

	// last sample lands with the done flop, so rx_sr is complete on done
	assign rx_frame = lsb_first ? bit_rev(rx_sr) : rx_sr;

	// busy covers the done cycle, select stays low through it
	assign busy = (state == spi_xfer_pkg::eng_shift) || frame_done;
	assign ss_n = busy ? ~(4'b0001 << slave_sel) : 4'b1111;

	// the sequencer must wait for done before the next frame
	a_no_start_busy: assert property (@(posedge pclk) disable iff (!preset_n)
		frame_start |-> !busy)
		else $error("spi_master_engine frame_start while busy");

endmodule

`default_nettype wire

// ==== spi_top.sv ====
// apb spi master, four clock modes, four active low slave selects
// single clock and reset, preset_n goes straight to every flop
`timescale 1ns/100ps
`default_nettype none

`include "spi_consts.svh"

module spi_top (
	input  wire logic                   pclk,
	input  wire logic                   preset_n,
	input  wire logic                   psel,
	input  wire logic                   penable,
	input  wire logic                   pwrite,
	input  wire logic [`SPI_APB_AW-1:0] paddr,
	input  wire logic [31:0]            pwdata,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	output logic                        sclk,
	output logic                        mosi,
	input  wire logic                   miso,
	output logic [3:0]                  ss_n
);

	spi_reg_pkg::ctrl_t   ctrl;
	spi_reg_pkg::timing_t timing;
	logic busy;
	logic fifo_clear;
	// tx path
	logic tx_push;
	logic tx_pop;
	logic tx_full;
	logic tx_empty;
	logic [`SPI_FIFO_AW:0] tx_level;
	spi_xfer_pkg::frame_t tx_wdata;
	spi_xfer_pkg::frame_t tx_rdata;
	// rx path
	logic rx_push;
	logic rx_pop;
	logic rx_full;
	logic rx_empty;
	logic [`SPI_FIFO_AW:0] rx_level;
	spi_xfer_pkg::frame_t rx_wdata;
	spi_xfer_pkg::frame_t rx_rdata;
	// sequencer to engine
	logic frame_start;
	logic frame_done;
	spi_xfer_pkg::frame_t frame_data;
	spi_xfer_pkg::frame_t rx_frame;

	spi_apb_regs regs (
		.pclk(pclk), .preset_n(preset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ctrl(ctrl), .timing(timing), .busy(busy),
		.tx_push(tx_push), .tx_wdata(tx_wdata), .tx_level(tx_level),
		.tx_full(tx_full), .tx_empty(tx_empty),
		.rx_pop(rx_pop), .rx_rdata(rx_rdata), .rx_level(rx_level),
		.rx_full(rx_full), .rx_empty(rx_empty), .fifo_clear(fifo_clear)
	);

	spi_fifo tx_fifo (
		.pclk(pclk), .preset_n(preset_n), .clear(fifo_clear),
		.push(tx_push), .wdata(tx_wdata), .pop(tx_pop), .rdata(tx_rdata),
		.level(tx_level), .full(tx_full), .empty(tx_empty)
	);

	spi_fifo rx_fifo (
		.pclk(pclk), .preset_n(preset_n), .clear(fifo_clear),
		.push(rx_push), .wdata(rx_wdata), .pop(rx_pop), .rdata(rx_rdata),
		.level(rx_level), .full(rx_full), .empty(rx_empty)
	);

	spi_sequencer seq (
		.pclk(pclk), .preset_n(preset_n),
		.enable(ctrl.enable), .soft_reset(ctrl.soft_reset), .frame_gap(timing.frame_gap),
		.tx_empty(tx_empty), .tx_rdata(tx_rdata), .tx_pop(tx_pop),
		.rx_full(rx_full), .rx_push(rx_push), .rx_wdata(rx_wdata),
		.frame_start(frame_start), .frame_data(frame_data),
		.frame_done(frame_done), .rx_frame(rx_frame)
	);

	spi_master_engine engine (
		.pclk(pclk), .preset_n(preset_n),
		.cpol(ctrl.cpol), .cpha(ctrl.cpha), .lsb_first(ctrl.lsb_first),
		.slave_sel(ctrl.slave_sel), .clk_div(timing.clk_div),
		.frame_start(frame_start), .frame_data(frame_data),
		.frame_done(frame_done), .rx_frame(rx_frame), .busy(busy),
		.sclk(sclk), .mosi(mosi), .miso(miso), .ss_n(ss_n)
	);

endmodule

`default_nettype wire

// ==== tb_spi_top.sv ====
// directed testbench for the apb spi master with miso looped back to mosi
// one apb access at a time, frames are awaited by polling STATUS
// the mosi monitor assumes ctrl only changes while the engine is idle
`timescale 1ns/100ps
`default_nettype none

`include "spi_consts.svh"

module tb_spi_top;

	// worst frame 16*4 half-period cycles + gap 3 + ~5, about 34 frames
	// plus status polling, then roughly x5 margin
	localparam int MAX_CYCLES = 20000;

	logic pclk;
	logic preset_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`SPI_APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic sclk;
	logic mosi;
	logic [3:0] ss_n;

	int errors;
	int checks;
	int tests;
	int cycles;
	string test_name;

	// mosi monitor settings written by the tests
	logic mon_on;
	logic mon_cpol;
	logic mon_cpha;
	logic [1:0] mon_sel;
	logic sclk_prev;
	logic [3:0] ss_exp;
	logic mon_bits[$];

	// miso tied to mosi for loopback
	spi_top i_spi_top (
		.pclk(pclk), .preset_n(preset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.sclk(sclk), .mosi(mosi), .miso(mosi), .ss_n(ss_n)
	);

	initial
	begin
		pclk = 1'b0;
		forever
			#2 pclk = ~pclk;
	end

	//==========================================================================
	// check, apb access, status helpers
	//==========================================================================
	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Mismatch in %s, %s: expected %h, actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [`SPI_APB_AW-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge pclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge pclk);
		penable <= 1'b1;
		// prdata and pslverr captured in setup stay stable through access
		@(negedge pclk);
		rdata = prdata;
		err = pslverr;
		check("pready", 32'd1, pready);
		@(posedge pclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [`SPI_APB_AW-1:0] addr, input logic [31:0] data,
		output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [`SPI_APB_AW-1:0] addr, output logic [31:0] data,
		output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	// write that must not error
	task automatic reg_write(input logic [`SPI_APB_AW-1:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check("pslverr on write", 32'd0, err);
	endtask

	task automatic read_expect(input string what, input logic [`SPI_APB_AW-1:0] addr,
		input logic [31:0] expected, input logic exp_err);
		logic [31:0] data;
		logic err;
		apb_read(addr, data, err);
		check({what, " pslverr"}, exp_err, err);
		if (!exp_err)
			check(what, expected, data);
	endtask

	task automatic read_status(output spi_reg_pkg::status_t st);
		logic [31:0] data;
		logic err;
		apb_read(`SPI_ADDR_STATUS, data, err);
		check("status pslverr", 32'd0, err);
		st = data;
	endtask

	// poll until n bytes are back and the engine is quiet
	task automatic wait_frames(input int n);
		spi_reg_pkg::status_t st;
		read_status(st);
		while (!(st.rx_level == n && st.tx_empty && !st.busy))
			read_status(st);
	endtask

	// ctrl only written while idle and the monitor rearmed once sclk has settled
	task automatic configure(input logic en, input logic cpol, input logic cpha,
		input logic lsb, input logic [1:0] sel);
		spi_reg_pkg::ctrl_t c;
		c = '0;
		c.enable = en;
		c.cpol = cpol;
		c.cpha = cpha;
		c.lsb_first = lsb;
		c.slave_sel = sel;
		mon_on = 1'b0;
		reg_write(`SPI_ADDR_CTRL, c);
		@(posedge pclk);
		mon_cpol = cpol;
		mon_cpha = cpha;
		mon_sel = sel;
		mon_bits.delete();
		mon_on = 1'b1;
	endtask

	function automatic logic [7:0] take_byte(input logic msb_first);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
		begin
			if (mon_bits.size() > 0)
			begin
				if (msb_first)
					v[7-i] = mon_bits.pop_front();
				else
					v[i] = mon_bits.pop_front();
			end
		end
		return v;
	endfunction

	task automatic end_test(input int start_errors);
		tests++;
		$display("test %s: %0d errors", test_name, errors - start_errors);
	endtask

	//==========================================================================
	// mosi monitor and timeout
	//==========================================================================
	// sampled at negedge where sclk and ss_n are settled
	always @(negedge pclk)
	begin
		if (mon_on)
		begin
			if (ss_n != 4'b1111)
			begin
				// only the selected line low
				ss_exp = 4'b1111;
				ss_exp[mon_sel] = 1'b0;
				check("ss_n during frame", ss_exp, ss_n);
				// sampling edge moves sclk to !cpol when cpha 0, to cpol when cpha 1
				if (sclk != sclk_prev && sclk == (mon_cpol ^ mon_cpha ^ 1'b1))
					mon_bits.push_back(mosi);
			end
			else
				check("sclk idle level", mon_cpol, sclk);
		end
		sclk_prev = sclk;
	end

	always @(posedge pclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	//==========================================================================
	// tests
	//==========================================================================
	task automatic reset_regs();
		int start;
		start = errors;
		test_name = "reset and registers";
		read_expect("ctrl after reset", `SPI_ADDR_CTRL, 32'h0, 1'b0);
		read_expect("timing after reset", `SPI_ADDR_TIMING, `SPI_TIMING_RESET, 1'b0);
		// enable and soft reset left clear with reserved bits set
		reg_write(`SPI_ADDR_CTRL, 32'hffff_ffbe);
		read_expect("ctrl masked", `SPI_ADDR_CTRL, 32'h0000_003e, 1'b0);
		reg_write(`SPI_ADDR_TIMING, 32'habcd_1234);
		read_expect("timing masked", `SPI_ADDR_TIMING, 32'h0000_1234, 1'b0);
		reg_write(`SPI_ADDR_CTRL, 32'h0);
		reg_write(`SPI_ADDR_TIMING, `SPI_TIMING_RESET);
		end_test(start);
	endtask

	task automatic bus_errors();
		int start;
		logic err;
		start = errors;
		test_name = "bus errors";
		read_expect("unaligned read", 5'h02, 32'h0, 1'b1);
		read_expect("out of range read", 5'h14, 32'h0, 1'b1);
		read_expect("txdata read", `SPI_ADDR_TXDATA, 32'h0, 1'b1);
		apb_write(`SPI_ADDR_STATUS, 32'hffff_ffff, err);
		check("status write pslverr", 32'd1, err);
		apb_write(`SPI_ADDR_RXDATA, 32'h0000_00aa, err);
		check("rxdata write pslverr", 32'd1, err);
		// erroring writes must leave the registers alone
		apb_write(5'h01, 32'h0000_003e, err);
		check("unaligned ctrl write pslverr", 32'd1, err);
		read_expect("ctrl untouched", `SPI_ADDR_CTRL, 32'h0, 1'b0);
		apb_write(5'h06, 32'h0000_ffff, err);
		check("unaligned timing write pslverr", 32'd1, err);
		read_expect("timing untouched", `SPI_ADDR_TIMING, `SPI_TIMING_RESET, 1'b0);
		end_test(start);
	endtask

	task automatic loopback_mode(input int mode);
		int start;
		logic [7:0] sent[$];
		logic [7:0] b;
		start = errors;
		test_name = $sformatf("loopback mode %0d", mode);
		// divider and gap follow the mode so gap 0 is covered
		reg_write(`SPI_ADDR_TIMING, {16'h0, 8'(mode), 8'(mode)});
		configure(1'b1, mode[1], mode[0], 1'b0, 2'(mode));
		for (int i = 0; i < 4; i++)
		begin
			b = 8'($urandom);
			sent.push_back(b);
			reg_write(`SPI_ADDR_TXDATA, {24'h0, b});
		end
		wait_frames(4);
		check("mosi bit count", 32'd32, mon_bits.size());
		for (int i = 0; i < 4; i++)
		begin
			check("mosi byte", sent[i], take_byte(1'b1));
			read_expect("rxdata", `SPI_ADDR_RXDATA, {24'h0, sent[i]}, 1'b0);
		end
		end_test(start);
	endtask

	task automatic bit_order(input logic lsb);
		int start;
		logic [7:0] sent[$];
		logic [7:0] b;
		start = errors;
		test_name = lsb ? "bit order lsb first" : "bit order msb first";
		reg_write(`SPI_ADDR_TIMING, `SPI_TIMING_RESET);
		configure(1'b1, 1'b0, 1'b0, lsb, 2'd1);
		for (int i = 0; i < 2; i++)
		begin
			b = 8'($urandom);
			sent.push_back(b);
			reg_write(`SPI_ADDR_TXDATA, {24'h0, b});
		end
		wait_frames(2);
		check("mosi bit count", 32'd16, mon_bits.size());
		if (mon_bits.size() > 0)
			check("first bit on wire", lsb ? sent[0][0] : sent[0][7], mon_bits[0]);
		for (int i = 0; i < 2; i++)
		begin
			check("mosi byte", sent[i], take_byte(!lsb));
			read_expect("rxdata", `SPI_ADDR_RXDATA, {24'h0, sent[i]}, 1'b0);
		end
		end_test(start);
	endtask

	task automatic fifo_limits();
		int start;
		logic [7:0] sent[$];
		logic [7:0] b;
		spi_reg_pkg::status_t st;
		start = errors;
		test_name = "fifo limits";
		reg_write(`SPI_ADDR_TIMING, `SPI_TIMING_RESET);
		configure(1'b0, 1'b0, 1'b0, 1'b0, 2'd0);
		// ninth byte finds the fifo full and is dropped
		for (int i = 0; i < 9; i++)
		begin
			b = 8'($urandom);
			sent.push_back(b);
			reg_write(`SPI_ADDR_TXDATA, {24'h0, b});
		end
		read_status(st);
		check("tx_level", 32'd8, st.tx_level);
		check("tx_full", 32'd1, st.tx_full);
		check("tx_overflow", 32'd1, st.tx_overflow);
		check("rx_overflow", 32'd0, st.rx_overflow);
		configure(1'b1, 1'b0, 1'b0, 1'b0, 2'd0);
		wait_frames(8);
		read_status(st);
		check("rx_full", 32'd1, st.rx_full);
		for (int i = 0; i < 8; i++)
			read_expect("rxdata", `SPI_ADDR_RXDATA, {24'h0, sent[i]}, 1'b0);
		read_expect("rxdata when empty", `SPI_ADDR_RXDATA, 32'h0, 1'b0);
		read_status(st);
		check("rx_overflow", 32'd1, st.rx_overflow);
		check("rx_empty", 32'd1, st.rx_empty);
		// leave bytes in both fifos before soft reset
		reg_write(`SPI_ADDR_TXDATA, 32'h0000_005a);
		reg_write(`SPI_ADDR_TXDATA, 32'h0000_00c3);
		wait_frames(2);
		configure(1'b0, 1'b0, 1'b0, 1'b0, 2'd0);
		for (int i = 0; i < 3; i++)
			reg_write(`SPI_ADDR_TXDATA, {24'h0, 8'(i)});
		read_status(st);
		check("tx_level before soft reset", 32'd3, st.tx_level);
		check("rx_level before soft reset", 32'd2, st.rx_level);
		reg_write(`SPI_ADDR_CTRL, 32'h0000_0040);
		read_status(st);
		check("tx_level in soft reset", 32'd0, st.tx_level);
		check("rx_level in soft reset", 32'd0, st.rx_level);
		check("tx_overflow in soft reset", 32'd0, st.tx_overflow);
		check("rx_overflow in soft reset", 32'd0, st.rx_overflow);
		reg_write(`SPI_ADDR_CTRL, 32'h0);
		read_status(st);
		check("tx_empty after soft reset", 32'd1, st.tx_empty);
		check("rx_empty after soft reset", 32'd1, st.rx_empty);
		check("tx_overflow after soft reset", 32'd0, st.tx_overflow);
		check("rx_overflow after soft reset", 32'd0, st.rx_overflow);
		end_test(start);
	endtask

	initial
	begin
		void'($urandom(60826));
		errors = 0;
		checks = 0;
		tests = 0;
		test_name = "reset";
		mon_on = 1'b0;
		mon_cpol = 1'b0;
		mon_cpha = 1'b0;
		mon_sel = 2'd0;
		sclk_prev = 1'b0;
		preset_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(posedge pclk);
		preset_n <= 1'b1;
		reset_regs();
		bus_errors();
		for (int m = 0; m < 4; m++)
			loopback_mode(m);
		bit_order(1'b0);
		bit_order(1'b1);
		fifo_limits();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
spi_reg_pkg.sv
spi_xfer_pkg.sv
spi_fifo.sv
spi_apb_regs.sv
spi_sequencer.sv
spi_master_engine.sv
spi_top.sv
tb_spi_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the spi master testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_spi_top -o tb_spi_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_spi_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
